// ==== ara_defines.svh ====
//////////////////////////////////////////////////////////////////////
// Vector unit front end: global sizes and accepted major opcodes
//////////////////////////////////////////////////////////////////////

`ifndef ARA_DEFINES_SVH
`define ARA_DEFINES_SVH

// Vector register length in bits
`define ARA_VLEN 256

// Instruction id width on the core interface
`define ARA_ID_W 4

// Entries in the issue ring buffer
`define ARA_BUF_DEPTH 8

// Major opcodes handed to the vector unit (OP-V, LOAD-FP, STORE-FP)
`define ARA_OPC_VEC    7'b1010111
`define ARA_OPC_VLOAD  7'b0000111
`define ARA_OPC_VSTORE 7'b0100111

`endif

// ==== xif_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Coprocessor interface channel types between the scalar core and
// the vector unit (issue, register, commit and result)
//////////////////////////////////////////////////////////////////////

`include "ara_defines.svh"

package xif_pkg;

  // Instruction id as tagged by the core
  typedef logic [`ARA_ID_W-1:0] xif_id_t;

  // Offered instruction
  typedef struct packed {
    logic [31:0] instr;
    xif_id_t     id;
  } xif_issue_t;

  // Scalar operands for an earlier offered instruction
  typedef struct packed {
    xif_id_t     id;
    logic [31:0] rs1;
    logic [31:0] rs2;
  } xif_register_t;

  // Commit or kill of an instruction
  typedef struct packed {
    xif_id_t id;
    logic    kill;
  } xif_commit_t;

  // Scalar writeback toward the core
  typedef struct packed {
    xif_id_t     id;
    logic [31:0] data;
  } xif_result_t;

endpackage

// ==== ara_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Vector unit internal types: instruction, CSR state, buffer entries
// and the request toward the sequencer
//////////////////////////////////////////////////////////////////////

package ara_pkg;

  typedef logic [31:0] instr_t;
  typedef logic [31:0] vl_t;

  // Only element width and the illegal flag are kept, LMUL is fixed to 1
  typedef struct packed {
    logic [2:0] vsew;
    logic       vill;
  } vtype_t;

  // Waiting instruction in the ring buffer
  typedef struct packed {
    instr_t           instr;
    xif_pkg::xif_id_t id;
  } buf_entry_t;

  // Request toward the sequencer
  typedef struct packed {
    instr_t           instr;
    xif_pkg::xif_id_t id;
    logic [31:0]      rs1;
    logic [31:0]      rs2;
    vl_t              vl;
    vtype_t           vtype;
  } ara_req_t;

  typedef enum logic {
    IDLE,
    WAIT_RESULT
  } disp_state_e;

endpackage

// ==== ara_lw_decoder.sv ====
//////////////////////////////////////////////////////////////////////
// Light decoder: accept verdict and vsetvli detection
//////////////////////////////////////////////////////////////////////

`include "ara_defines.svh"

module ara_lw_decoder (
  input  ara_pkg::instr_t instr_i,
  output logic            accept_o,
  output logic            is_vsetvli_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];

  always_comb begin
    accept_o     = 1'b0;
    is_vsetvli_o = 1'b0;
    case (opcode)
      `ARA_OPC_VEC: begin
        accept_o = 1'b1;
        // OPCFG space, vsetvli has bit 31 clear
        if (funct3 == 3'b111 && !instr_i[31]) begin
          is_vsetvli_o = 1'b1;
        end
      end
      `ARA_OPC_VLOAD,
      `ARA_OPC_VSTORE: begin
        accept_o = 1'b1;
      end
      default: begin
        accept_o = 1'b0;
      end
    endcase
  end

endmodule

// ==== ara_ring_buffer.sv ====
//////////////////////////////////////////////////////////////////////
// Id-tagged instruction ring buffer with kill flush that drops the
// matching entry and every entry pushed after it
//////////////////////////////////////////////////////////////////////

`include "ara_defines.svh"

module ara_ring_buffer (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                push_i,
  input  logic                pop_i,
  input  logic                flush_i,
  input  xif_pkg::xif_id_t    flush_id_i,
  input  ara_pkg::buf_entry_t data_i,
  output ara_pkg::buf_entry_t data_o,
  output logic                full_o,
  output logic                empty_o
);

  import ara_pkg::*;

  localparam int unsigned PTR_W = $clog2(`ARA_BUF_DEPTH);

  buf_entry_t       mem [`ARA_BUF_DEPTH];
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W:0]   count_q;

  logic             flush_hit;
  logic [PTR_W:0]   flush_off;

  assign data_o  = mem[rd_ptr_q];
  assign full_o  = (count_q == (PTR_W+1)'(`ARA_BUF_DEPTH));
  assign empty_o = (count_q == '0);

  //////////////////////////////////////////////////////////////////////
  // Flush search, oldest entry first
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    logic [PTR_W-1:0] idx;
    flush_hit = 1'b0;
    flush_off = '0;
    for (int i = 0; i < `ARA_BUF_DEPTH; i++) begin
      idx = rd_ptr_q + PTR_W'(i);
      if (!flush_hit && i < count_q && mem[idx].id == flush_id_i) begin
        flush_hit = 1'b1;
        flush_off = (PTR_W+1)'(i);
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push_i && !full_o) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i && flush_hit) begin
      // Younger entries simply fall off behind the new write pointer
      wr_ptr_q <= rd_ptr_q + flush_off[PTR_W-1:0];
      count_q  <= flush_off;
    end else begin
      if (push_i && !full_o) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i && !empty_o) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push_i && !full_o, pop_i && !empty_o})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

// ==== ara_issue_front.sv ====
//////////////////////////////////////////////////////////////////////
// Issue front end: accept gating, instruction buffering and hand-off
// to the dispatcher when operands arrive
//////////////////////////////////////////////////////////////////////

module ara_issue_front (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  issue_valid_i,
  input  xif_pkg::xif_issue_t   issue_i,
  input  logic                  register_valid_i,
  input  logic                  commit_valid_i,
  input  xif_pkg::xif_commit_t  commit_i,
  output logic                  issue_ready_o,
  output logic                  issue_accept_o,
  output logic                  register_ready_o,
  input  logic                  disp_ready_i,
  output logic                  disp_push_o,
  output ara_pkg::buf_entry_t   disp_entry_o
);

  import ara_pkg::*;

  logic       kill;
  logic       dec_accept;
  logic       buf_full;
  logic       buf_empty;
  logic       push;
  buf_entry_t push_entry;

  assign kill = commit_valid_i && commit_i.kill;

  ara_lw_decoder u_decoder (
    .instr_i      (issue_i.instr),
    .accept_o     (dec_accept   ),
    .is_vsetvli_o (             )
  );

  // Nothing moves in or out of the buffer while a kill is applied
  assign issue_ready_o    = !buf_full && !kill;
  assign issue_accept_o   = dec_accept;
  assign push             = issue_valid_i && issue_ready_o && dec_accept;
  assign register_ready_o = !buf_empty && disp_ready_i && !kill;
  assign disp_push_o      = register_valid_i && register_ready_o;

  assign push_entry = '{instr: issue_i.instr, id: issue_i.id};

  ara_ring_buffer u_ring_buffer (
    .clk_i      (clk_i       ),
    .rst_i      (rst_i       ),
    .push_i     (push        ),
    .pop_i      (disp_push_o ),
    .flush_i    (kill        ),
    .flush_id_i (commit_i.id ),
    .data_i     (push_entry  ),
    .data_o     (disp_entry_o),
    .full_o     (buf_full    ),
    .empty_o    (buf_empty   )
  );

endmodule

// ==== ara_dispatcher.sv ====
//////////////////////////////////////////////////////////////////////
// Dispatcher: pairs instructions with scalar operands, keeps vl and
// vtype, executes vsetvli and issues vector requests
//////////////////////////////////////////////////////////////////////

`include "ara_defines.svh"

module ara_dispatcher (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  push_i,
  input  ara_pkg::buf_entry_t   entry_i,
  input  xif_pkg::xif_register_t rs_i,
  output logic                  ready_o,
  output ara_pkg::ara_req_t     ara_req_o,
  output logic                  ara_req_valid_o,
  input  logic                  ara_req_ready_i,
  output xif_pkg::xif_result_t  result_o,
  output logic                  result_valid_o,
  input  logic                  result_ready_i
);

  import ara_pkg::*;
  import xif_pkg::*;

  disp_state_e state_q;
  logic        req_valid_q;
  ara_req_t    req_q;
  xif_result_t result_q;
  vl_t         vl_q;
  vtype_t      vtype_q;

  logic        is_vsetvli;
  vtype_t      new_vtype;
  vl_t         vlmax;
  vl_t         new_vl;

  ara_lw_decoder u_decoder (
    .instr_i      (entry_i.instr),
    .accept_o     (             ),
    .is_vsetvli_o (is_vsetvli   )
  );

  //////////////////////////////////////////////////////////////////////
  // vsetvli evaluation
  //////////////////////////////////////////////////////////////////////

  // vsew above 3 (64-bit elements) is illegal here
  assign new_vtype.vsew = entry_i.instr[25:23];
  assign new_vtype.vill = entry_i.instr[25];

  // VLEN / (8 * 2^vsew)
  assign vlmax  = vl_t'(`ARA_VLEN / 8) >> new_vtype.vsew[1:0];
  assign new_vl = new_vtype.vill ? '0 : ((rs_i.rs1 < vlmax) ? rs_i.rs1 : vlmax);

  // Both output slots must be free before taking the next instruction
  assign ready_o         = !req_valid_q && (state_q == IDLE);
  assign ara_req_o       = req_q;
  assign ara_req_valid_o = req_valid_q;
  assign result_o        = result_q;
  assign result_valid_o  = (state_q == WAIT_RESULT);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q     <= IDLE;
      req_valid_q <= 1'b0;
      vl_q        <= '0;
      vtype_q     <= '{vsew: 3'd0, vill: 1'b1};
    end else begin
      if (req_valid_q && ara_req_ready_i) begin
        req_valid_q <= 1'b0;
      end
      case (state_q)
        IDLE: begin
          if (push_i && is_vsetvli) begin
            state_q <= WAIT_RESULT;
            vl_q    <= new_vl;
            vtype_q <= new_vtype;
          end else if (push_i) begin
            req_valid_q <= 1'b1;
          end
        end
        WAIT_RESULT: begin
          if (result_ready_i) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Payload registers
  always_ff @(posedge clk_i) begin
    if (push_i && ready_o) begin
      if (is_vsetvli) begin
        result_q <= '{id: entry_i.id, data: new_vl};
      end else begin
        req_q <= '{instr: entry_i.instr, id: entry_i.id, rs1: rs_i.rs1,
                   rs2: rs_i.rs2, vl: vl_q, vtype: vtype_q};
      end
    end
  end

endmodule

// ==== ara.sv ====
//////////////////////////////////////////////////////////////////////
// Vector unit top level: issue front end and dispatcher
//////////////////////////////////////////////////////////////////////

module ara (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   issue_valid_i,
  input  xif_pkg::xif_issue_t    issue_i,
  input  logic                   register_valid_i,
  input  xif_pkg::xif_register_t register_i,
  input  logic                   commit_valid_i,
  input  xif_pkg::xif_commit_t   commit_i,
  input  logic                   ara_req_ready_i,
  input  logic                   result_ready_i,
  output logic                   issue_ready_o,
  output logic                   issue_accept_o,
  output logic                   register_ready_o,
  output ara_pkg::ara_req_t      ara_req_o,
  output logic                   ara_req_valid_o,
  output xif_pkg::xif_result_t   result_o,
  output logic                   result_valid_o
);

  import ara_pkg::*;

  // Front end to dispatcher
  logic       disp_ready;
  logic       disp_push;
  buf_entry_t disp_entry;

  ara_issue_front u_issue_front (
    .clk_i            (clk_i           ),
    .rst_i            (rst_i           ),
    .issue_valid_i    (issue_valid_i   ),
    .issue_i          (issue_i         ),
    .register_valid_i (register_valid_i),
    .commit_valid_i   (commit_valid_i  ),
    .commit_i         (commit_i        ),
    .issue_ready_o    (issue_ready_o   ),
    .issue_accept_o   (issue_accept_o  ),
    .register_ready_o (register_ready_o),
    .disp_ready_i     (disp_ready      ),
    .disp_push_o      (disp_push       ),
    .disp_entry_o     (disp_entry      )
  );

  ara_dispatcher u_dispatcher (
    .clk_i           (clk_i          ),
    .rst_i           (rst_i          ),
    .push_i          (disp_push      ),
    .entry_i         (disp_entry     ),
    .rs_i            (register_i     ),
    .ready_o         (disp_ready     ),
    .ara_req_o       (ara_req_o      ),
    .ara_req_valid_o (ara_req_valid_o),
    .ara_req_ready_i (ara_req_ready_i),
    .result_o        (result_o       ),
    .result_valid_o  (result_valid_o ),
    .result_ready_i  (result_ready_i )
  );

endmodule

// ==== tb_ara.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench for the vector unit front end: random issue, operand and
// kill traffic checked against a queue model with vl/vtype state
//////////////////////////////////////////////////////////////////////

`include "ara_defines.svh"

module tb_ara;

  timeunit 1ns;
  timeprecision 1ps;

  import ara_pkg::*;
  import xif_pkg::*;

  localparam int TIMEOUT = 100;

  logic          clk_i;
  logic          rst_i;
  logic          issue_valid_i;
  xif_issue_t    issue_i;
  logic          register_valid_i;
  xif_register_t register_i;
  logic          commit_valid_i;
  xif_commit_t   commit_i;
  logic          ara_req_ready_i;
  logic          result_ready_i;
  logic          issue_ready_o;
  logic          issue_accept_o;
  logic          register_ready_o;
  ara_req_t      ara_req_o;
  logic          ara_req_valid_o;
  xif_result_t   result_o;
  logic          result_valid_o;

  // Model state
  buf_entry_t model_q[$];
  vl_t        model_vl;
  vtype_t     model_vtype;
  xif_id_t    next_id;

  integer seed;
  int     errors;
  int     test_errors;
  int     tests_run;
  int     tests_failed;

  ara u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////////////////////////
  // Reference rules for accept and vl
  //////////////////////////////////////////////////////////////////////

  function automatic logic accepts_opcode(input instr_t instr);
    return instr[6:0] == `ARA_OPC_VEC || instr[6:0] == `ARA_OPC_VLOAD ||
           instr[6:0] == `ARA_OPC_VSTORE;
  endfunction

  function automatic vl_t expected_vl(input logic [2:0] vsew, input vl_t avl);
    vl_t vlmax;
    if (vsew > 3'd3) begin
      return '0;
    end
    vlmax = `ARA_VLEN / (8 << vsew);
    return (avl < vlmax) ? avl : vlmax;
  endfunction

  // Vector op, load or store, never a vsetvli
  function automatic instr_t make_vec_instr();
    instr_t instr;
    instr = $random(seed);
    case ($random(seed) & 3)
      0, 1: begin
        instr[6:0] = `ARA_OPC_VEC;
        if (instr[14:12] == 3'b111) begin
          instr[14:12] = 3'b000;
        end
      end
      2:       instr[6:0] = `ARA_OPC_VLOAD;
      default: instr[6:0] = `ARA_OPC_VSTORE;
    endcase
    return instr;
  endfunction

  function automatic instr_t make_vsetvli(input logic [2:0] vsew);
    instr_t instr;
    instr        = $random(seed);
    instr[31]    = 1'b0;
    instr[25:23] = vsew;
    instr[14:12] = 3'b111;
    instr[6:0]   = `ARA_OPC_VEC;
    return instr;
  endfunction

  task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  task automatic start_test();
    test_errors = errors;
    tests_run++;
  endtask

  task automatic end_test(input string name);
    if (errors == test_errors) begin
      $display("Test %0d %-28s passed", tests_run, name);
    end else begin
      tests_failed++;
      $display("Test %0d %-28s failed, %0d errors", tests_run, name, errors - test_errors);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Bus tasks, all driving on the falling edge
  //////////////////////////////////////////////////////////////////////

  task automatic issue_instr(input instr_t instr);
    int   n;
    logic done;
    n    = 0;
    done = 1'b0;
    @(negedge clk_i);
    issue_valid_i = 1'b1;
    issue_i       = '{instr: instr, id: next_id};
    while (!done && n < TIMEOUT) begin
      #1;
      if (issue_ready_o) begin
        check_hex("issue_accept_o", 32'(issue_accept_o), 32'(accepts_opcode(instr)));
        if (accepts_opcode(instr)) begin
          model_q.push_back('{instr: instr, id: next_id});
          next_id = xif_id_t'(next_id + 1);
        end
        done = 1'b1;
      end
      @(negedge clk_i);
      n++;
    end
    issue_valid_i = 1'b0;
    assert (done) else begin
      $display("Timeout: issue_ready_o never went high");
      errors++;
    end
  endtask

  // Pops the model head once the DUT takes the operands
  task automatic deliver_operands(input logic [31:0] rs1, input logic [31:0] rs2,
                                  output buf_entry_t popped);
    int   n;
    logic done;
    n      = 0;
    done   = 1'b0;
    popped = model_q[0];
    @(negedge clk_i);
    register_valid_i = 1'b1;
    register_i       = '{id: popped.id, rs1: rs1, rs2: rs2};
    while (!done && n < TIMEOUT) begin
      #1;
      done = register_ready_o;
      @(negedge clk_i);
      n++;
    end
    register_valid_i = 1'b0;
    if (done) begin
      void'(model_q.pop_front());
    end
    assert (done) else begin
      $display("Timeout: register_ready_o never went high");
      errors++;
    end
  endtask

  // Random ready stalls, payload compared on every valid cycle
  task automatic expect_request(input ara_req_t exp);
    int   n;
    logic done;
    n    = 0;
    done = 1'b0;
    while (!done && n < TIMEOUT) begin
      ara_req_ready_i = (($random(seed) & 3) == 0);
      check_hex("result_valid_o", 32'(result_valid_o), 32'h0);
      if (ara_req_valid_o) begin
        check_hex("ara_req_o.instr", ara_req_o.instr, exp.instr);
        check_hex("ara_req_o.id", 32'(ara_req_o.id), 32'(exp.id));
        check_hex("ara_req_o.rs1", ara_req_o.rs1, exp.rs1);
        check_hex("ara_req_o.rs2", ara_req_o.rs2, exp.rs2);
        check_hex("ara_req_o.vl", ara_req_o.vl, exp.vl);
        check_hex("ara_req_o.vtype", 32'(ara_req_o.vtype), 32'(exp.vtype));
        done = ara_req_ready_i;
      end
      @(negedge clk_i);
      n++;
    end
    ara_req_ready_i = 1'b0;
    assert (done) else begin
      $display("Timeout: no vector request was handed over");
      errors++;
    end
  endtask

  task automatic expect_result(input xif_id_t id, input vl_t vl);
    int   n;
    logic done;
    n    = 0;
    done = 1'b0;
    while (!done && n < TIMEOUT) begin
      result_ready_i = (($random(seed) & 3) == 0);
      if (result_valid_o) begin
        check_hex("result_o.id", 32'(result_o.id), 32'(id));
        check_hex("result_o.data", result_o.data, vl);
        done = result_ready_i;
      end
      @(negedge clk_i);
      n++;
    end
    result_ready_i = 1'b0;
    assert (done) else begin
      $display("Timeout: no vsetvli result was handed over");
      errors++;
    end
  endtask

  // Operands for the model head, then the request it should produce
  task automatic run_head_request();
    buf_entry_t popped;
    logic [31:0] rs1;
    logic [31:0] rs2;
    rs1 = $random(seed);
    rs2 = $random(seed);
    deliver_operands(rs1, rs2, popped);
    expect_request('{instr: popped.instr, id: popped.id, rs1: rs1, rs2: rs2,
                     vl: model_vl, vtype: model_vtype});
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    buf_entry_t  popped;
    logic [2:0]  vsew;
    logic [31:0] avl;
    int          kill_idx;
    seed             = 32'h72d0_83a3;
    errors           = 0;
    tests_run        = 0;
    tests_failed     = 0;
    next_id          = '0;
    model_vl         = '0;
    model_vtype      = '{vsew: 3'd0, vill: 1'b1};
    rst_i            = 1'b1;
    issue_valid_i    = 1'b0;
    issue_i          = '0;
    register_valid_i = 1'b0;
    register_i       = '0;
    commit_valid_i   = 1'b0;
    commit_i         = '0;
    ara_req_ready_i  = 1'b0;
    result_ready_i   = 1'b0;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;

    start_test();
    #1;
    check_hex("register_ready_o", 32'(register_ready_o), 32'h0);
    check_hex("ara_req_valid_o", 32'(ara_req_valid_o), 32'h0);
    check_hex("result_valid_o", 32'(result_valid_o), 32'h0);
    check_hex("issue_ready_o", 32'(issue_ready_o), 32'h1);
    end_test("reset state");

    // Accept verdict is combinational, so no valid is needed
    start_test();
    for (int i = 0; i < 24; i++) begin
      @(negedge clk_i);
      issue_i.instr = (i % 2 == 0) ? make_vec_instr() : instr_t'($random(seed));
      #1;
      check_hex("issue_accept_o", 32'(issue_accept_o), 32'(accepts_opcode(issue_i.instr)));
    end
    end_test("opcode accept rule");

    start_test();
    for (int i = 0; i < `ARA_BUF_DEPTH; i++) begin
      issue_instr(make_vec_instr());
    end
    #1;
    check_hex("issue_ready_o", 32'(issue_ready_o), 32'h0);
    end_test("full buffer back-pressure");

    start_test();
    for (int i = 0; i < `ARA_BUF_DEPTH; i++) begin
      run_head_request();
      if (i == 0) begin
        #1;
        check_hex("issue_ready_o", 32'(issue_ready_o), 32'h1);
      end
    end
    end_test("in-order requests");

    start_test();
    for (int i = 0; i < 6; i++) begin
      vsew = $random(seed);
      avl  = $random(seed) & 32'h3f;
      issue_instr(make_vsetvli(vsew));
      deliver_operands(avl, $random(seed), popped);
      expect_result(popped.id, expected_vl(vsew, avl));
      model_vl    = expected_vl(vsew, avl);
      model_vtype = '{vsew: vsew, vill: vsew > 3'd3};
      issue_instr(make_vec_instr());
      run_head_request();
    end
    end_test("vsetvli and vl update");

    start_test();
    for (int i = 0; i < 5; i++) begin
      issue_instr(make_vec_instr());
    end
    kill_idx = $unsigned($random(seed)) % 5;
    @(negedge clk_i);
    commit_valid_i = 1'b1;
    commit_i       = '{id: model_q[kill_idx].id, kill: 1'b1};
    #1;
    check_hex("issue_ready_o", 32'(issue_ready_o), 32'h0);
    check_hex("register_ready_o", 32'(register_ready_o), 32'h0);
    @(negedge clk_i);
    commit_valid_i = 1'b0;
    while (model_q.size() > kill_idx) begin
      void'(model_q.pop_back());
    end
    // Survivors are the entries older than the killed one
    for (int i = 0; i < kill_idx; i++) begin
      run_head_request();
    end
    #1;
    check_hex("register_ready_o", 32'(register_ready_o), 32'h0);
    end_test("kill flush");

    $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+.
xif_pkg.sv
ara_pkg.sv
ara_lw_decoder.sv
ara_ring_buffer.sv
ara_issue_front.sv
ara_dispatcher.sv
ara.sv
tb_ara.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the vector unit front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_ara -f sources.f -o tb_ara_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_ara_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Finished with errors" "$LOG"; then
  exit 1
fi
exit 0
